// File: source/cp0_reg_pkg.sv
`default_nettype none

package cp0_reg_pkg;

    typedef logic [31:0] cp0_word_t;

    // Address is {rd, sel}
    typedef logic [7:0] cp0_addr_t;

    typedef logic [7:0] int_vec_t;
    typedef logic [5:0] ext_int_t;

    localparam cp0_addr_t cr_badvaddr = 8'b01000_000;
    localparam cp0_addr_t cr_count    = 8'b01001_000;
    localparam cp0_addr_t cr_compare  = 8'b01011_000;
    localparam cp0_addr_t cr_status   = 8'b01100_000;
    localparam cp0_addr_t cr_cause    = 8'b01101_000;
    localparam cp0_addr_t cr_epc      = 8'b01110_000;
    localparam cp0_addr_t cr_prid     = 8'b01111_000;

    // Status fields
    localparam int status_cu0_bit = 28;
    localparam int status_bev_bit = 22;
    localparam int status_im_lsb  = 8;
    localparam int status_um_bit  = 4;
    localparam int status_exl_bit = 1;
    localparam int status_ie_bit  = 0;

    // Cause fields
    localparam int cause_bd_bit     = 31;
    localparam int cause_ti_bit     = 30;
    localparam int cause_iv_bit     = 23;
    localparam int cause_ip_lsb     = 8;
    localparam int cause_excode_lsb = 2;

endpackage

`default_nettype wire

// File: source/cp0_exc_pkg.sv
`default_nettype none

package cp0_exc_pkg;

    typedef logic [4:0] excode_t;

    // TLB and address error codes
    localparam excode_t exc_mod  = 5'd1;
    localparam excode_t exc_tlbl = 5'd2;
    localparam excode_t exc_tlbs = 5'd3;
    localparam excode_t exc_adel = 5'd4;
    localparam excode_t exc_ades = 5'd5;

    // Codes that latch the faulting address
    function automatic logic records_badvaddr(excode_t code);
        return (code == exc_mod) || (code == exc_tlbl) || (code == exc_tlbs) ||
               (code == exc_adel) || (code == exc_ades);
    endfunction

endpackage

`default_nettype wire

// File: source/cp0_mtc0_decode.sv
`default_nettype none

module cp0_mtc0_decode (
    input  cp0_reg_pkg::cp0_addr_t inst1_c0_addr,
    input  cp0_reg_pkg::cp0_word_t inst1_c0_wdata,
    input  logic                   inst1_mtc0_we,
    input  cp0_reg_pkg::cp0_addr_t inst2_c0_addr,
    input  cp0_reg_pkg::cp0_word_t inst2_c0_wdata,
    input  logic                   inst2_mtc0_we,
    output logic                   status_we,
    output cp0_reg_pkg::cp0_word_t status_wdata,
    output logic                   cause_we,
    output cp0_reg_pkg::cp0_word_t cause_wdata,
    output logic                   epc_we,
    output cp0_reg_pkg::cp0_word_t epc_wdata,
    output logic                   count_we,
    output cp0_reg_pkg::cp0_word_t count_wdata,
    output logic                   compare_we,
    output cp0_reg_pkg::cp0_word_t compare_wdata
);
    import cp0_reg_pkg::*;

    localparam int nregs = 5;
    localparam cp0_addr_t reg_addr [nregs] = '{cr_status, cr_cause, cr_epc, cr_count, cr_compare};

    logic [nregs-1:0] hit1;
    logic [nregs-1:0] hit2;
    cp0_word_t        wdata [nregs];

    always_comb begin
        for (int i = 0; i < nregs; i++) begin
            hit1[i] = inst1_mtc0_we && (inst1_c0_addr == reg_addr[i]);
            hit2[i] = inst2_mtc0_we && (inst2_c0_addr == reg_addr[i]);
            // Slot 2 is younger and wins
            wdata[i] = hit2[i] ? inst2_c0_wdata : inst1_c0_wdata;
        end
    end

    assign status_we     = hit1[0] | hit2[0];
    assign status_wdata  = wdata[0];
    assign cause_we      = hit1[1] | hit2[1];
    assign cause_wdata   = wdata[1];
    assign epc_we        = hit1[2] | hit2[2];
    assign epc_wdata     = wdata[2];
    assign count_we      = hit1[3] | hit2[3];
    assign count_wdata   = wdata[3];
    assign compare_we    = hit1[4] | hit2[4];
    assign compare_wdata = wdata[4];

endmodule

`default_nettype wire

// File: source/cp0_status_cause.sv
`default_nettype none

module cp0_status_cause (
    input  logic                   cp0_clk,
    input  logic                   reset,
    input  logic                   status_we,
    input  cp0_reg_pkg::cp0_word_t status_wdata,
    input  logic                   cause_we,
    input  cp0_reg_pkg::cp0_word_t cause_wdata,
    input  logic                   pms_ex,
    input  logic                   pms_eret,
    input  logic                   pms_bd,
    input  cp0_exc_pkg::excode_t   ex_type,
    input  cp0_reg_pkg::ext_int_t  ext_int_in,
    input  logic                   timer_int,
    output cp0_reg_pkg::cp0_word_t c0_status,
    output cp0_reg_pkg::cp0_word_t c0_cause,
    output logic                   status_exl,
    output logic                   has_int
);
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    logic     cu0;
    logic     bev;
    int_vec_t im;
    logic     um;
    logic     exl;
    logic     ie;

    logic       bd;
    logic       iv;
    logic [7:2] hw_ip;
    logic [1:0] sw_ip;
    int_vec_t   ip;
    excode_t    excode;

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            cu0 <= 1'b0;
            bev <= 1'b1;
            um  <= 1'b0;
            ie  <= 1'b0;
        end else if (status_we) begin
            cu0 <= status_wdata[status_cu0_bit];
            bev <= status_wdata[status_bev_bit];
            um  <= status_wdata[status_um_bit];
            ie  <= status_wdata[status_ie_bit];
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (status_we) begin
            im <= status_wdata[status_im_lsb +: 8];
        end
    end

    // Exception entry beats eret, eret beats software
    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (pms_ex) begin
            exl <= 1'b1;
        end else if (pms_eret) begin
            exl <= 1'b0;
        end else if (status_we) begin
            exl <= status_wdata[status_exl_bit];
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            bd     <= 1'b0;
            excode <= '0;
        end else if (pms_ex) begin
            excode <= ex_type;
            // Nested exception keeps the original BD
            if (!exl) begin
                bd <= pms_bd;
            end
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            iv    <= 1'b0;
            sw_ip <= '0;
        end else if (cause_we) begin
            iv    <= cause_wdata[cause_iv_bit];
            sw_ip <= cause_wdata[cause_ip_lsb +: 2];
        end
    end

    // IP7 shares the line with the timer
    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            hw_ip <= '0;
        end else begin
            hw_ip[7]   <= ext_int_in[5] | timer_int;
            hw_ip[6:2] <= ext_int_in[4:0];
        end
    end

    assign ip = {hw_ip, sw_ip};

    always_comb begin
        c0_status = '0;
        c0_status[status_cu0_bit]     = cu0;
        c0_status[status_bev_bit]     = bev;
        c0_status[status_im_lsb +: 8] = im;
        c0_status[status_um_bit]      = um;
        c0_status[status_exl_bit]     = exl;
        c0_status[status_ie_bit]      = ie;

        c0_cause = '0;
        c0_cause[cause_bd_bit]           = bd;
        c0_cause[cause_ti_bit]           = timer_int;
        c0_cause[cause_iv_bit]           = iv;
        c0_cause[cause_ip_lsb +: 8]      = ip;
        c0_cause[cause_excode_lsb +: 5]  = excode;
    end

    assign status_exl = exl;
    assign has_int    = ((ip & im) != '0) && ie && !exl;

endmodule

`default_nettype wire

// File: source/cp0_exc_capture.sv
`default_nettype none

module cp0_exc_capture (
    input  logic                   cp0_clk,
    input  logic                   reset,
    input  logic                   pms_ex,
    input  logic                   pms_bd,
    input  cp0_reg_pkg::cp0_word_t pms_pc,
    input  cp0_reg_pkg::cp0_word_t pms_badvaddr,
    input  cp0_exc_pkg::excode_t   ex_type,
    input  logic                   status_exl,
    input  logic                   epc_we,
    input  cp0_reg_pkg::cp0_word_t epc_wdata,
    output cp0_reg_pkg::cp0_word_t c0_epc,
    output cp0_reg_pkg::cp0_word_t c0_badvaddr
);
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    cp0_word_t exc_pc;

    // Delay slot points back at the branch
    assign exc_pc = pms_bd ? (pms_pc - 32'd4) : pms_pc;

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            c0_epc <= '0;
        end else if (pms_ex && !status_exl) begin
            c0_epc <= exc_pc;
        end else if (epc_we) begin
            c0_epc <= epc_wdata;
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            c0_badvaddr <= '0;
        end else if (pms_ex && records_badvaddr(ex_type)) begin
            c0_badvaddr <= pms_badvaddr;
        end
    end

endmodule

`default_nettype wire

// File: source/cp0_timer.sv
`default_nettype none

module cp0_timer #(
    parameter int count_tick_div = 2
) (
    input  logic                   cp0_clk,
    input  logic                   reset,
    input  logic                   count_we,
    input  cp0_reg_pkg::cp0_word_t count_wdata,
    input  logic                   compare_we,
    input  cp0_reg_pkg::cp0_word_t compare_wdata,
    output cp0_reg_pkg::cp0_word_t c0_count,
    output cp0_reg_pkg::cp0_word_t c0_compare,
    output logic                   timer_int
);
    localparam int div_w = (count_tick_div > 1) ? $clog2(count_tick_div) : 1;

    logic [div_w-1:0] div_cnt;
    logic             tick;
    logic             match;

    assign tick = (div_cnt == div_w'(count_tick_div - 1));

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Software write overrides the step
    always_ff @(posedge cp0_clk) begin
        if (count_we) begin
            c0_count <= count_wdata;
        end else if (tick) begin
            c0_count <= c0_count + 32'd1;
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (compare_we) begin
            c0_compare <= compare_wdata;
        end
    end

    // Zero Compare disables the timer
    assign match = (c0_count == c0_compare) && (c0_compare != '0);

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (compare_we) begin
            timer_int <= 1'b0;
        end else if (match) begin
            timer_int <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/cp0_read_mux.sv
`default_nettype none

module cp0_read_mux #(
    parameter cp0_reg_pkg::cp0_word_t prid_value = 32'h0000_4220
) (
    input  cp0_reg_pkg::cp0_addr_t c0_addr,
    input  cp0_reg_pkg::cp0_word_t c0_status,
    input  cp0_reg_pkg::cp0_word_t c0_cause,
    input  cp0_reg_pkg::cp0_word_t c0_epc,
    input  cp0_reg_pkg::cp0_word_t c0_badvaddr,
    input  cp0_reg_pkg::cp0_word_t c0_count,
    input  cp0_reg_pkg::cp0_word_t c0_compare,
    output cp0_reg_pkg::cp0_word_t c0_rdata
);
    import cp0_reg_pkg::*;

    always_comb begin
        case (c0_addr)
            cr_status: begin
                c0_rdata = c0_status;
            end
            cr_cause: begin
                c0_rdata = c0_cause;
            end
            cr_epc: begin
                c0_rdata = c0_epc;
            end
            cr_badvaddr: begin
                c0_rdata = c0_badvaddr;
            end
            cr_count: begin
                c0_rdata = c0_count;
            end
            cr_compare: begin
                c0_rdata = c0_compare;
            end
            cr_prid: begin
                c0_rdata = prid_value;
            end
            // Unimplemented registers read as zero
            default: begin
                c0_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/cp0_top.sv
`default_nettype none

module cp0_top #(
    parameter int                     count_tick_div = 2,
    parameter cp0_reg_pkg::cp0_word_t prid_value     = 32'h0000_4220
) (
    input  logic                   cp0_clk,
    input  logic                   reset,
    input  cp0_reg_pkg::cp0_addr_t inst1_c0_addr,
    input  cp0_reg_pkg::cp0_word_t inst1_c0_wdata,
    input  logic                   inst1_mtc0_we,
    input  cp0_reg_pkg::cp0_addr_t inst2_c0_addr,
    input  cp0_reg_pkg::cp0_word_t inst2_c0_wdata,
    input  logic                   inst2_mtc0_we,
    input  logic                   pms_ex,
    input  cp0_exc_pkg::excode_t   ex_type,
    input  logic                   pms_bd,
    input  cp0_reg_pkg::cp0_word_t pms_pc,
    input  cp0_reg_pkg::cp0_word_t pms_badvaddr,
    input  logic                   pms_eret,
    input  cp0_reg_pkg::ext_int_t  ext_int_in,
    output cp0_reg_pkg::cp0_word_t inst1_c0_rdata,
    output cp0_reg_pkg::cp0_word_t inst2_c0_rdata,
    output logic                   has_int,
    output cp0_reg_pkg::cp0_word_t epc_res,
    output cp0_reg_pkg::cp0_word_t c0_status,
    output cp0_reg_pkg::cp0_word_t c0_cause
);
    import cp0_reg_pkg::*;

    logic      status_we;
    logic      cause_we;
    logic      epc_we;
    logic      count_we;
    logic      compare_we;
    cp0_word_t status_wdata;
    cp0_word_t cause_wdata;
    cp0_word_t epc_wdata;
    cp0_word_t count_wdata;
    cp0_word_t compare_wdata;

    logic      timer_int;
    logic      status_exl;
    cp0_word_t c0_epc;
    cp0_word_t c0_badvaddr;
    cp0_word_t c0_count;
    cp0_word_t c0_compare;

    cp0_mtc0_decode u_decode (
        .inst1_c0_addr (inst1_c0_addr),
        .inst1_c0_wdata(inst1_c0_wdata),
        .inst1_mtc0_we (inst1_mtc0_we),
        .inst2_c0_addr (inst2_c0_addr),
        .inst2_c0_wdata(inst2_c0_wdata),
        .inst2_mtc0_we (inst2_mtc0_we),
        .status_we     (status_we),
        .status_wdata  (status_wdata),
        .cause_we      (cause_we),
        .cause_wdata   (cause_wdata),
        .epc_we        (epc_we),
        .epc_wdata     (epc_wdata),
        .count_we      (count_we),
        .count_wdata   (count_wdata),
        .compare_we    (compare_we),
        .compare_wdata (compare_wdata)
    );

    cp0_status_cause u_status_cause (
        .cp0_clk     (cp0_clk),
        .reset       (reset),
        .status_we   (status_we),
        .status_wdata(status_wdata),
        .cause_we    (cause_we),
        .cause_wdata (cause_wdata),
        .pms_ex      (pms_ex),
        .pms_eret    (pms_eret),
        .pms_bd      (pms_bd),
        .ex_type     (ex_type),
        .ext_int_in  (ext_int_in),
        .timer_int   (timer_int),
        .c0_status   (c0_status),
        .c0_cause    (c0_cause),
        .status_exl  (status_exl),
        .has_int     (has_int)
    );

    cp0_exc_capture u_exc_capture (
        .cp0_clk     (cp0_clk),
        .reset       (reset),
        .pms_ex      (pms_ex),
        .pms_bd      (pms_bd),
        .pms_pc      (pms_pc),
        .pms_badvaddr(pms_badvaddr),
        .ex_type     (ex_type),
        .status_exl  (status_exl),
        .epc_we      (epc_we),
        .epc_wdata   (epc_wdata),
        .c0_epc      (c0_epc),
        .c0_badvaddr (c0_badvaddr)
    );

    cp0_timer #(
        .count_tick_div(count_tick_div)
    ) u_timer (
        .cp0_clk      (cp0_clk),
        .reset        (reset),
        .count_we     (count_we),
        .count_wdata  (count_wdata),
        .compare_we   (compare_we),
        .compare_wdata(compare_wdata),
        .c0_count     (c0_count),
        .c0_compare   (c0_compare),
        .timer_int    (timer_int)
    );

    // One read port per issue slot
    cp0_read_mux #(
        .prid_value(prid_value)
    ) u_read1 (
        .c0_addr    (inst1_c0_addr),
        .c0_status  (c0_status),
        .c0_cause   (c0_cause),
        .c0_epc     (c0_epc),
        .c0_badvaddr(c0_badvaddr),
        .c0_count   (c0_count),
        .c0_compare (c0_compare),
        .c0_rdata   (inst1_c0_rdata)
    );

    cp0_read_mux #(
        .prid_value(prid_value)
    ) u_read2 (
        .c0_addr    (inst2_c0_addr),
        .c0_status  (c0_status),
        .c0_cause   (c0_cause),
        .c0_epc     (c0_epc),
        .c0_badvaddr(c0_badvaddr),
        .c0_count   (c0_count),
        .c0_compare (c0_compare),
        .c0_rdata   (inst2_c0_rdata)
    );

    assign epc_res = c0_epc;

endmodule

`default_nettype wire

// File: testbench/cp0_tb.sv
`default_nettype none

module cp0_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    localparam int        tick_div  = 2;
    localparam cp0_word_t prid      = 32'h0000_4220;
    localparam int        timer_gap = 5;

    // Rough cycle budget per test
    localparam int len_reset     = 10 + 10;
    localparam int len_write     = 40;
    localparam int len_exception = 30;
    localparam int len_interrupt = 45;
    localparam int len_timer     = tick_div * timer_gap + 25;
    localparam int timeout_limit = len_reset + len_write + len_exception + len_interrupt +
                                   len_timer + 100;

    localparam cp0_word_t status_mask = (32'h1 << status_cu0_bit) | (32'h1 << status_bev_bit) |
                                        (32'hFF << status_im_lsb) | (32'h1 << status_um_bit) |
                                        (32'h1 << status_exl_bit) | (32'h1 << status_ie_bit);
    localparam cp0_word_t cause_exc_mask = (32'h1 << cause_bd_bit) | (32'h1F << cause_excode_lsb);
    localparam cp0_word_t bev_only = 32'h1 << status_bev_bit;

    logic      cp0_clk;
    logic      reset;
    cp0_addr_t inst1_c0_addr;
    cp0_word_t inst1_c0_wdata;
    logic      inst1_mtc0_we;
    cp0_addr_t inst2_c0_addr;
    cp0_word_t inst2_c0_wdata;
    logic      inst2_mtc0_we;
    logic      pms_ex;
    excode_t   ex_type;
    logic      pms_bd;
    cp0_word_t pms_pc;
    cp0_word_t pms_badvaddr;
    logic      pms_eret;
    ext_int_t  ext_int_in;
    cp0_word_t inst1_c0_rdata;
    cp0_word_t inst2_c0_rdata;
    logic      has_int;
    cp0_word_t epc_res;
    cp0_word_t c0_status;
    cp0_word_t c0_cause;

    logic [31:0] lfsr_state = 32'd80;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    cp0_top #(
        .count_tick_div(tick_div),
        .prid_value    (prid)
    ) DUT (
        .cp0_clk       (cp0_clk),
        .reset         (reset),
        .inst1_c0_addr (inst1_c0_addr),
        .inst1_c0_wdata(inst1_c0_wdata),
        .inst1_mtc0_we (inst1_mtc0_we),
        .inst2_c0_addr (inst2_c0_addr),
        .inst2_c0_wdata(inst2_c0_wdata),
        .inst2_mtc0_we (inst2_mtc0_we),
        .pms_ex        (pms_ex),
        .ex_type       (ex_type),
        .pms_bd        (pms_bd),
        .pms_pc        (pms_pc),
        .pms_badvaddr  (pms_badvaddr),
        .pms_eret      (pms_eret),
        .ext_int_in    (ext_int_in),
        .inst1_c0_rdata(inst1_c0_rdata),
        .inst2_c0_rdata(inst2_c0_rdata),
        .has_int       (has_int),
        .epc_res       (epc_res),
        .c0_status     (c0_status),
        .c0_cause      (c0_cause)
    );

    initial begin
        cp0_clk = 1'b0;
    end

    always #10 cp0_clk = ~cp0_clk;

    always @(posedge cp0_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic cp0_word_t random_word();
        cp0_word_t w;
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic compare_word(input string what, input cp0_word_t got, input cp0_word_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("test %-12s FAIL (%0d errors)", name, error_count - errors_at_start);
        end else begin
            $display("test %-12s PASS", name);
        end
    endtask

    task automatic write_slot(input int slot, input cp0_addr_t addr, input cp0_word_t data);
        @(negedge cp0_clk);
        if (slot == 1) begin
            inst1_c0_addr  = addr;
            inst1_c0_wdata = data;
            inst1_mtc0_we  = 1'b1;
        end else begin
            inst2_c0_addr  = addr;
            inst2_c0_wdata = data;
            inst2_mtc0_we  = 1'b1;
        end
        @(negedge cp0_clk);
        inst1_mtc0_we = 1'b0;
        inst2_mtc0_we = 1'b0;
    endtask

    task automatic write_both(input cp0_addr_t addr1, input cp0_word_t data1,
                              input cp0_addr_t addr2, input cp0_word_t data2);
        @(negedge cp0_clk);
        inst1_c0_addr  = addr1;
        inst1_c0_wdata = data1;
        inst1_mtc0_we  = 1'b1;
        inst2_c0_addr  = addr2;
        inst2_c0_wdata = data2;
        inst2_mtc0_we  = 1'b1;
        @(negedge cp0_clk);
        inst1_mtc0_we = 1'b0;
        inst2_mtc0_we = 1'b0;
    endtask

    // Both read ports look at the same register
    task automatic check_read(input string what, input cp0_addr_t addr, input cp0_word_t mask,
                              input cp0_word_t expected);
        @(negedge cp0_clk);
        inst1_c0_addr = addr;
        inst2_c0_addr = addr;
        #2;
        compare_word({what, " (port 1)"}, inst1_c0_rdata & mask, expected & mask);
        compare_word({what, " (port 2)"}, inst2_c0_rdata & mask, expected & mask);
    endtask

    task automatic raise_exception(input excode_t code, input logic bd, input cp0_word_t pc,
                                   input cp0_word_t badvaddr);
        @(negedge cp0_clk);
        pms_ex       = 1'b1;
        ex_type      = code;
        pms_bd       = bd;
        pms_pc       = pc;
        pms_badvaddr = badvaddr;
        @(negedge cp0_clk);
        pms_ex = 1'b0;
        pms_bd = 1'b0;
    endtask

    task automatic return_from_exception();
        @(negedge cp0_clk);
        pms_eret = 1'b1;
        @(negedge cp0_clk);
        pms_eret = 1'b0;
    endtask

    task automatic wait_has_int(input string what, input logic level, input int bound);
        for (int i = 0; i < bound && has_int !== level; i++) begin
            @(negedge cp0_clk);
        end
        compare_bit(what, has_int, level);
    endtask

    // TI and IP7 both visible in Cause
    function automatic logic timer_flags_set();
        return c0_cause[cause_ti_bit] && c0_cause[cause_ip_lsb + 7];
    endfunction

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        // IM has no reset value
        check_read("Status", cr_status, ~(32'hFF << status_im_lsb), bev_only);
        check_read("Cause", cr_cause, '1, 32'h0);
        check_read("EPC", cr_epc, '1, 32'h0);
        check_read("BadVAddr", cr_badvaddr, '1, 32'h0);
        check_read("PRID", cr_prid, '1, prid);
        compare_bit("has_int", has_int, 1'b0);
        end_test("reset", errs);
    endtask

    task automatic test_write_read();
        int        errs;
        cp0_word_t d1;
        cp0_word_t d2;
        errs = error_count;
        for (int slot = 1; slot <= 2; slot++) begin
            d1 = random_word();
            write_slot(slot, cr_epc, d1);
            check_read("EPC", cr_epc, '1, d1);
            d1 = random_word();
            write_slot(slot, cr_compare, d1);
            check_read("Compare", cr_compare, '1, d1);
            d1 = random_word();
            write_slot(slot, cr_status, d1);
            check_read("Status", cr_status, '1, d1 & status_mask);
        end
        d1 = random_word();
        d2 = random_word();
        write_both(cr_epc, d1, cr_epc, d2);
        check_read("EPC after dual write", cr_epc, '1, d2);
        d1 = random_word();
        d2 = random_word();
        write_both(cr_compare, d1, cr_compare, d2);
        check_read("Compare after dual write", cr_compare, '1, d2);
        write_slot(1, cr_status, bev_only);
        end_test("write_read", errs);
    endtask

    task automatic test_exception();
        int        errs;
        cp0_word_t pc;
        cp0_word_t bva;
        cp0_word_t exp_epc;
        cp0_word_t exp_bva;
        errs = error_count;

        pc = random_word() & ~32'h3;
        bva = random_word();
        raise_exception(5'd4, 1'b0, pc, bva);
        exp_epc = pc;
        exp_bva = bva;
        check_read("Status after AdEL", cr_status, '1, bev_only | (32'h1 << status_exl_bit));
        check_read("Cause after AdEL", cr_cause, cause_exc_mask, 32'd4 << cause_excode_lsb);
        check_read("EPC after AdEL", cr_epc, '1, exp_epc);
        check_read("BadVAddr after AdEL", cr_badvaddr, '1, exp_bva);
        compare_word("epc_res", epc_res, exp_epc);
        return_from_exception();
        check_read("Status after eret", cr_status, '1, bev_only);

        // Syscall in a delay slot
        pc = random_word() & ~32'h3;
        raise_exception(5'd8, 1'b1, pc, random_word());
        exp_epc = pc - 32'd4;
        check_read("Cause after Sys", cr_cause, cause_exc_mask,
                   (32'h1 << cause_bd_bit) | (32'd8 << cause_excode_lsb));
        check_read("EPC after Sys", cr_epc, '1, exp_epc);
        check_read("BadVAddr after Sys", cr_badvaddr, '1, exp_bva);

        // Nested TLBL keeps EPC but records the address
        bva = random_word();
        raise_exception(5'd2, 1'b0, random_word() & ~32'h3, bva);
        exp_bva = bva;
        check_read("EPC after nested", cr_epc, '1, exp_epc);
        check_read("BadVAddr after nested", cr_badvaddr, '1, exp_bva);
        compare_bit("EXL after nested", c0_status[status_exl_bit], 1'b1);
        return_from_exception();
        compare_bit("EXL after second eret", c0_status[status_exl_bit], 1'b0);
        end_test("exception", errs);
    endtask

    task automatic test_interrupt();
        int        errs;
        cp0_word_t im2_ie;
        cp0_word_t im0_ie;
        errs = error_count;
        im2_ie = bev_only | (32'h1 << (status_im_lsb + 2)) | (32'h1 << status_ie_bit);
        im0_ie = bev_only | (32'h1 << status_im_lsb) | (32'h1 << status_ie_bit);

        write_slot(1, cr_status, im2_ie);
        ext_int_in = 6'b000001;
        wait_has_int("has_int on line 0", 1'b1, 2);
        write_slot(2, cr_status, im2_ie & ~(32'h1 << status_ie_bit));
        compare_bit("has_int with IE clear", has_int, 1'b0);
        write_slot(1, cr_status, im2_ie);
        compare_bit("has_int with IE set again", has_int, 1'b1);
        write_slot(1, cr_status, im2_ie | (32'h1 << status_exl_bit));
        compare_bit("has_int with EXL set", has_int, 1'b0);
        write_slot(1, cr_status, im2_ie);
        @(negedge cp0_clk);
        ext_int_in = '0;
        wait_has_int("has_int after line drops", 1'b0, 2);

        // Software interrupt 0
        write_slot(1, cr_status, im0_ie);
        write_slot(2, cr_cause, 32'h1 << cause_ip_lsb);
        compare_bit("has_int on soft IP0", has_int, 1'b1);
        write_slot(1, cr_status, im0_ie & ~(32'h1 << status_ie_bit));
        compare_bit("has_int soft IP0 with IE clear", has_int, 1'b0);
        write_slot(1, cr_status, im0_ie | (32'h1 << status_exl_bit));
        compare_bit("has_int soft IP0 with EXL set", has_int, 1'b0);
        write_slot(1, cr_status, bev_only);
        write_slot(2, cr_cause, 32'h0);
        end_test("interrupt", errs);
    endtask

    task automatic test_timer();
        int        errs;
        int        bound;
        cp0_word_t base;
        errs = error_count;
        bound = tick_div * timer_gap + 3;
        base = random_word() & 32'h7FFF_FFFF;
        write_both(cr_count, base, cr_compare, base + timer_gap);
        for (int i = 0; i < bound && !timer_flags_set(); i++) begin
            @(negedge cp0_clk);
        end
        if (!timer_flags_set()) begin
            error_count++;
            $display("Timer interrupt did not reach Cause within %0d cycles", bound);
        end
        compare_bit("Cause.TI", c0_cause[cause_ti_bit], 1'b1);
        compare_bit("Cause.IP7", c0_cause[cause_ip_lsb + 7], 1'b1);
        write_slot(1, cr_status, bev_only | (32'h1 << (status_im_lsb + 7)) |
                   (32'h1 << status_ie_bit));
        compare_bit("has_int on timer", has_int, 1'b1);
        write_slot(2, cr_compare, 32'h0);
        compare_bit("Cause.TI after Compare write", c0_cause[cause_ti_bit], 1'b0);
        wait_has_int("has_int after Compare write", 1'b0, 2);
        write_slot(1, cr_status, bev_only);
        end_test("timer", errs);
    endtask

    initial begin
        reset          = 1'b1;
        inst1_c0_addr  = '0;
        inst1_c0_wdata = '0;
        inst1_mtc0_we  = 1'b0;
        inst2_c0_addr  = '0;
        inst2_c0_wdata = '0;
        inst2_mtc0_we  = 1'b0;
        pms_ex         = 1'b0;
        ex_type        = '0;
        pms_bd         = 1'b0;
        pms_pc         = '0;
        pms_badvaddr   = '0;
        pms_eret       = 1'b0;
        ext_int_in     = '0;
        repeat (10) @(negedge cp0_clk);
        reset = 1'b0;

        test_reset_state();
        test_write_read();
        test_exception();
        test_interrupt();
        test_timer();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/cp0_reg_pkg.sv
source/cp0_exc_pkg.sv
source/cp0_mtc0_decode.sv
source/cp0_status_cause.sv
source/cp0_exc_capture.sv
source/cp0_timer.sv
source/cp0_read_mux.sv
source/cp0_top.sv
testbench/cp0_tb.sv

// File: Bender.yml
package:
  name: cp0

sources:
  - source/cp0_reg_pkg.sv
  - source/cp0_exc_pkg.sv
  - source/cp0_mtc0_decode.sv
  - source/cp0_status_cause.sv
  - source/cp0_exc_capture.sv
  - source/cp0_timer.sv
  - source/cp0_read_mux.sv
  - source/cp0_top.sv
  - target: test
    files:
      - testbench/cp0_tb.sv
